/* mailbox.f */
+incdir+source
source/mbox_pkg.sv
source/mbox_fifo.sv
source/mbox_resp_slice.sv
source/mbox_port_regs.sv
source/mbox_top.sv
tb/mbox_tb.sv

/* run.sh */
#!/bin/sh
# build the mailbox testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mbox_tb -f mailbox.f

out=$(./obj_dir/Vmbox_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'test passed'

/* source/mbox_consts.svh */
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

// bus geometry
`define MBOX_DATA_W       32          // one bus word
`define MBOX_ADDR_W       8           // byte address, ten word registers fit easily

// message fifo
`define MBOX_DEPTH        8           // words per direction
`define MBOX_USAGE_W      4           // holds 0 .. depth

// register map
`define MBOX_NUM_REGS     10

// fixed read values
`define MBOX_MBOXW_RDVAL  32'hFEEDC0DE // mailbox write reg is write only
`define MBOX_EMPTY_RDVAL  32'hFEEDDEAD // returned on read of an empty mailbox

`endif

/* source/mbox_fifo.sv */
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_fifo #(
  parameter int unsigned DEPTH = `MBOX_DEPTH
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i, // drops every stored word
  input  logic             push_i,
  input  mbox_pkg::data_t  data_i,
  input  logic             pop_i,
  output mbox_pkg::data_t  data_o,  // head word, valid while usage_o != 0
  output mbox_pkg::usage_t usage_o
);
  import mbox_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  data_t            mem_q [DEPTH];          // message storage
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  usage_t           count_q;
  logic             do_push, do_pop;        // flush overrides both

  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & ~flush_i;

  // ----------------------------------------
  // pointers and fill count
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither
      endcase
    end
  end

  // storage, written only on a real push
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q]; // show head without a pop
  assign usage_o = count_q;

  // ----------------------------------------
  // the port logic must check fill level before touching the fifo
  a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> (count_q != usage_t'(DEPTH)))
    else $error("mbox_fifo push while full");

  a_no_underflow : assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> (count_q != '0))
    else $error("mbox_fifo pop while empty");

endmodule

/* source/mbox_pkg.sv */
`include "mbox_consts.svh"

package mbox_pkg;

  typedef logic [`MBOX_DATA_W-1:0]  data_t;  // one bus word
  typedef logic [`MBOX_ADDR_W-1:0]  addr_t;  // byte address
  typedef logic [`MBOX_USAGE_W-1:0] usage_t; // fifo fill count

  // word index into the register map
  typedef enum logic [3:0] {
    MBOXW  = 4'd0, // push a message
    MBOXR  = 4'd1, // pop a message
    STATUS = 4'd2,
    ERROR  = 4'd3, // clear on read
    WIRQT  = 4'd4, // write side threshold
    RIRQT  = 4'd5, // read side threshold
    IRQS   = 4'd6, // write one to clear
    IRQEN  = 4'd7,
    IRQP   = 4'd8, // status and enable
    CTRL   = 4'd9  // flush strobes
  } reg_e;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } resp_e;

  // r channel beat, data first then resp
  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_beat_t;

endpackage

/* source/mbox_port_regs.sv */
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_port_regs (
  input  logic              clk_i,
  input  logic              rst_i,
  // write address and data
  input  logic              awvalid_i,
  output logic              awready_o,
  input  mbox_pkg::addr_t   awaddr_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  input  mbox_pkg::data_t   wdata_i,
  // read address
  input  logic              arvalid_i,
  output logic              arready_o,
  input  mbox_pkg::addr_t   araddr_i,
  // b and r response slices
  output logic              b_valid_o,
  output mbox_pkg::resp_e   b_resp_o,
  input  logic              b_ready_i,
  output logic              r_valid_o,
  output mbox_pkg::r_beat_t r_beat_o,
  input  logic              r_ready_i,
  // message fifos
  input  mbox_pkg::usage_t  w_usage_i, // fifo this port writes
  input  mbox_pkg::usage_t  r_usage_i, // fifo this port reads
  input  mbox_pkg::data_t   r_head_i,
  output logic              push_o,
  output mbox_pkg::data_t   push_data_o,
  output logic              pop_o,
  output logic              w_flush_o,
  output logic              r_flush_o,
  output logic              irq_o       // level, active high
);
  import mbox_pkg::*;

  localparam int unsigned IDX_W = `MBOX_ADDR_W - 2; // word index width

  logic [IDX_W-1:0] w_idx, r_idx;
  logic             w_hit, r_hit;     // index inside the map
  reg_e             w_reg, r_reg;
  logic             w_acc, r_acc;     // request taken this cycle
  logic             r_empty, w_full;
  logic             wr_err, rd_err;   // push to full, pop from empty
  logic [3:0]       status;
  logic [1:0]       error_q, error_d; // bit0 read empty, bit1 write full
  usage_t           wirqt_q, wirqt_d;
  usage_t           rirqt_q, rirqt_d;
  logic [2:0]       irqs_q,  irqs_d;  // bit0 write thr, bit1 read thr, bit2 error
  logic [2:0]       irqen_q, irqen_d;
  logic [2:0]       irqp;

  // threshold write, saturates at depth - 1 so a full fifo still fires
  function automatic usage_t clamp_thr(data_t val);
    if (val >= data_t'(`MBOX_DEPTH)) begin
      return usage_t'(`MBOX_DEPTH - 1);
    end
    return usage_t'(val);
  endfunction

  // ----------------------------------------
  // decode and handshake
  assign w_idx = awaddr_i[`MBOX_ADDR_W-1:2];
  assign r_idx = araddr_i[`MBOX_ADDR_W-1:2];
  assign w_hit = (w_idx < IDX_W'(`MBOX_NUM_REGS));
  assign r_hit = (r_idx < IDX_W'(`MBOX_NUM_REGS));
  assign w_reg = reg_e'(w_idx[3:0]);
  assign r_reg = reg_e'(r_idx[3:0]);

  // aw and w are taken together, only when the b slice has room
  assign w_acc     = awvalid_i & wvalid_i & b_ready_i;
  assign awready_o = w_acc;
  assign wready_o  = w_acc;
  assign b_valid_o = w_acc;
  assign r_acc     = arvalid_i & r_ready_i;
  assign arready_o = r_acc;
  assign r_valid_o = r_acc;

  // fifo state as seen by this port
  assign r_empty = (r_usage_i == '0);
  assign w_full  = (w_usage_i == usage_t'(`MBOX_DEPTH));
  assign status  = {r_usage_i > rirqt_q, w_usage_i > wirqt_q, w_full, r_empty};

  assign wr_err = w_acc & w_hit & (w_reg == MBOXW) & w_full;
  assign rd_err = r_acc & r_hit & (r_reg == MBOXR) & r_empty;

  assign push_data_o = wdata_i;   // full word, no strobes
  assign irqp        = irqs_q & irqen_q;
  assign irq_o       = |irqp;

  // ----------------------------------------
  // register access
  always_comb begin
    b_resp_o  = OKAY;
    r_beat_o  = '{data: '0, resp: OKAY};
    push_o    = 1'b0;
    pop_o     = 1'b0;
    w_flush_o = 1'b0;
    r_flush_o = 1'b0;
    error_d   = error_q;
    wirqt_d   = wirqt_q;
    rirqt_d   = rirqt_q;
    irqs_d    = irqs_q;
    irqen_d   = irqen_q;

    // read side, clears happen here
    if (r_acc) begin
      if (!r_hit) begin
        r_beat_o.resp = SLVERR; // out of map, data stays zero
      end else begin
        unique case (r_reg)
          MBOXW:  r_beat_o.data = `MBOX_MBOXW_RDVAL;
          MBOXR: begin
            if (!r_empty) begin
              r_beat_o.data = r_head_i;
              pop_o         = 1'b1;
            end else begin
              r_beat_o.data = `MBOX_EMPTY_RDVAL;
              r_beat_o.resp = SLVERR;
            end
          end
          STATUS: r_beat_o.data = data_t'(status);
          ERROR: begin
            r_beat_o.data = data_t'(error_q);
            error_d       = '0;          // clear on read
          end
          WIRQT:  r_beat_o.data = data_t'(wirqt_q);
          RIRQT:  r_beat_o.data = data_t'(rirqt_q);
          IRQS:   r_beat_o.data = data_t'(irqs_q);
          IRQEN:  r_beat_o.data = data_t'(irqen_q);
          IRQP:   r_beat_o.data = data_t'(irqp);
          default: ;                     // ctrl reads zero
        endcase
      end
    end

    // write side
    if (w_acc) begin
      if (!w_hit) begin
        b_resp_o = SLVERR;
      end else begin
        unique case (w_reg)
          MBOXW: begin
            if (!w_full) push_o = 1'b1;
            else         b_resp_o = SLVERR;
          end
          WIRQT:  wirqt_d = clamp_thr(wdata_i);
          RIRQT:  rirqt_d = clamp_thr(wdata_i);
          IRQS:   irqs_d  = irqs_q & ~wdata_i[2:0]; // write one to clear
          IRQEN:  irqen_d = wdata_i[2:0];
          CTRL: begin
            w_flush_o = wdata_i[0];
            r_flush_o = wdata_i[1];
          end
          default: ;                     // read only, ignored
        endcase
      end
    end

    // sets last, a set in the clearing cycle wins
    if (status[2]) irqs_d[0] = 1'b1;
    if (status[3]) irqs_d[1] = 1'b1;
    if (rd_err) begin
      error_d[0] = 1'b1;
      irqs_d[2]  = 1'b1;
    end
    if (wr_err) begin
      error_d[1] = 1'b1;
      irqs_d[2]  = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      error_q <= '0;
      wirqt_q <= '0;
      rirqt_q <= '0;
      irqs_q  <= '0;
      irqen_q <= '0;
    end else begin
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
    end
  end

  // a threshold at depth could never be exceeded by the fill count
  a_thr_below_depth : assert property (@(posedge clk_i) disable iff (rst_i)
    (wirqt_q < usage_t'(`MBOX_DEPTH)) && (rirqt_q < usage_t'(`MBOX_DEPTH)))
    else $error("mbox_port_regs threshold reached depth");

endmodule

/* source/mbox_resp_slice.sv */
`timescale 1ns/1ps

module mbox_resp_slice #(
  parameter type beat_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  // request side
  input  logic  valid_i,
  input  beat_t data_i,
  output logic  ready_o, // high only while empty
  // bus side
  output logic  valid_o,
  input  logic  ready_i,
  output beat_t data_o
);

  logic  full_q; // one beat held
  beat_t data_q; // held payload

  // ----------------------------------------
  // occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (valid_i && !full_q) begin
      full_q <= 1'b1;       // capture
    end else if (ready_i) begin
      full_q <= 1'b0;       // beat taken by the master
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !full_q) begin
      data_q <= data_i;
    end
  end

  // ready does not look at ready_i, so the bus ready never reaches the decode
  assign ready_o = ~full_q;
  assign valid_o = full_q;
  assign data_o  = data_q;

  // a stalled response must hold its payload and stay valid
  a_stable_beat : assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("mbox_resp_slice beat changed while stalled");

endmodule

/* source/mbox_top.sv */
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_top (
  input  logic              clk_i,
  input  logic              rst_i,
  // ---------------------------------------- port 0
  input  logic              awvalid_p0_i,
  output logic              awready_p0_o,
  input  mbox_pkg::addr_t   awaddr_p0_i,
  input  logic              wvalid_p0_i,
  output logic              wready_p0_o,
  input  mbox_pkg::data_t   wdata_p0_i,
  output logic              bvalid_p0_o,
  input  logic              bready_p0_i,
  output mbox_pkg::resp_e   bresp_p0_o,
  input  logic              arvalid_p0_i,
  output logic              arready_p0_o,
  input  mbox_pkg::addr_t   araddr_p0_i,
  output logic              rvalid_p0_o,
  input  logic              rready_p0_i,
  output mbox_pkg::data_t   rdata_p0_o,
  output mbox_pkg::resp_e   rresp_p0_o,
  // ---------------------------------------- port 1
  input  logic              awvalid_p1_i,
  output logic              awready_p1_o,
  input  mbox_pkg::addr_t   awaddr_p1_i,
  input  logic              wvalid_p1_i,
  output logic              wready_p1_o,
  input  mbox_pkg::data_t   wdata_p1_i,
  output logic              bvalid_p1_o,
  input  logic              bready_p1_i,
  output mbox_pkg::resp_e   bresp_p1_o,
  input  logic              arvalid_p1_i,
  output logic              arready_p1_o,
  input  mbox_pkg::addr_t   araddr_p1_i,
  output logic              rvalid_p1_o,
  input  logic              rready_p1_i,
  output mbox_pkg::data_t   rdata_p1_o,
  output mbox_pkg::resp_e   rresp_p1_o,
  output logic [1:0]        irq_o       // one level irq per port
);
  import mbox_pkg::*;

  // per port, index is the port
  logic [1:0] b_valid, b_ready, r_valid, r_ready;
  resp_e      b_resp [2];
  r_beat_t    r_beat [2];
  r_beat_t    r_out  [2];   // slice outputs, split onto rdata/rresp
  logic [1:0] push, pop, w_flush, r_flush;
  data_t      push_data [2];
  // per fifo, 0 is a (port 0 to port 1), 1 is b
  usage_t     usage [2];
  data_t      head  [2];

  mbox_port_regs i_port_0 (
    .clk_i, .rst_i,
    .awvalid_i   (awvalid_p0_i), .awready_o (awready_p0_o), .awaddr_i (awaddr_p0_i),
    .wvalid_i    (wvalid_p0_i),  .wready_o  (wready_p0_o),  .wdata_i  (wdata_p0_i),
    .arvalid_i   (arvalid_p0_i), .arready_o (arready_p0_o), .araddr_i (araddr_p0_i),
    .b_valid_o   (b_valid[0]),   .b_resp_o  (b_resp[0]),    .b_ready_i (b_ready[0]),
    .r_valid_o   (r_valid[0]),   .r_beat_o  (r_beat[0]),    .r_ready_i (r_ready[0]),
    .w_usage_i   (usage[0]),     .r_usage_i (usage[1]),     .r_head_i  (head[1]),
    .push_o      (push[0]),      .push_data_o (push_data[0]), .pop_o   (pop[0]),
    .w_flush_o   (w_flush[0]),   .r_flush_o (r_flush[0]),   .irq_o     (irq_o[0])
  );

  mbox_port_regs i_port_1 (
    .clk_i, .rst_i,
    .awvalid_i   (awvalid_p1_i), .awready_o (awready_p1_o), .awaddr_i (awaddr_p1_i),
    .wvalid_i    (wvalid_p1_i),  .wready_o  (wready_p1_o),  .wdata_i  (wdata_p1_i),
    .arvalid_i   (arvalid_p1_i), .arready_o (arready_p1_o), .araddr_i (araddr_p1_i),
    .b_valid_o   (b_valid[1]),   .b_resp_o  (b_resp[1]),    .b_ready_i (b_ready[1]),
    .r_valid_o   (r_valid[1]),   .r_beat_o  (r_beat[1]),    .r_ready_i (r_ready[1]),
    .w_usage_i   (usage[1]),     .r_usage_i (usage[0]),     .r_head_i  (head[0]),
    .push_o      (push[1]),      .push_data_o (push_data[1]), .pop_o   (pop[1]),
    .w_flush_o   (w_flush[1]),   .r_flush_o (r_flush[1]),   .irq_o     (irq_o[1])
  );

  // fifo a, written by port 0, drained by port 1
  mbox_fifo #(.DEPTH(`MBOX_DEPTH)) i_fifo_a (
    .clk_i, .rst_i,
    .flush_i (w_flush[0] | r_flush[1]), // either side may flush
    .push_i  (push[0]),
    .data_i  (push_data[0]),
    .pop_i   (pop[1]),
    .data_o  (head[0]),
    .usage_o (usage[0])
  );

  // fifo b, the reverse direction
  mbox_fifo #(.DEPTH(`MBOX_DEPTH)) i_fifo_b (
    .clk_i, .rst_i,
    .flush_i (w_flush[1] | r_flush[0]),
    .push_i  (push[1]),
    .data_i  (push_data[1]),
    .pop_i   (pop[0]),
    .data_o  (head[1]),
    .usage_o (usage[1])
  );

  // ---------------------------------------- response slices
  mbox_resp_slice #(.beat_t(resp_e)) i_b_slice_0 (
    .clk_i, .rst_i,
    .valid_i (b_valid[0]), .data_i (b_resp[0]), .ready_o (b_ready[0]),
    .valid_o (bvalid_p0_o), .ready_i (bready_p0_i), .data_o (bresp_p0_o)
  );

  mbox_resp_slice #(.beat_t(resp_e)) i_b_slice_1 (
    .clk_i, .rst_i,
    .valid_i (b_valid[1]), .data_i (b_resp[1]), .ready_o (b_ready[1]),
    .valid_o (bvalid_p1_o), .ready_i (bready_p1_i), .data_o (bresp_p1_o)
  );

  mbox_resp_slice #(.beat_t(r_beat_t)) i_r_slice_0 (
    .clk_i, .rst_i,
    .valid_i (r_valid[0]), .data_i (r_beat[0]), .ready_o (r_ready[0]),
    .valid_o (rvalid_p0_o), .ready_i (rready_p0_i), .data_o (r_out[0])
  );

  mbox_resp_slice #(.beat_t(r_beat_t)) i_r_slice_1 (
    .clk_i, .rst_i,
    .valid_i (r_valid[1]), .data_i (r_beat[1]), .ready_o (r_ready[1]),
    .valid_o (rvalid_p1_o), .ready_i (rready_p1_i), .data_o (r_out[1])
  );

  // r beat onto the loose bus ports
  assign rdata_p0_o = r_out[0].data;
  assign rresp_p0_o = r_out[0].resp;
  assign rdata_p1_o = r_out[1].data;
  assign rresp_p1_o = r_out[1].resp;

endmodule

/* tb/mbox_tb.sv */
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_tb;
  import mbox_pkg::*;

  localparam int CLK_HALF       = 20;       // 40 ns period
  localparam int RST_CYCLES     = 10;
  localparam int TIMEOUT_CYCLES = 400 * 50; // about 400 accesses of under 50 cycles each

  // register byte offsets
  localparam addr_t A_MBOXW  = 8'h00;
  localparam addr_t A_MBOXR  = 8'h04;
  localparam addr_t A_STATUS = 8'h08;
  localparam addr_t A_ERROR  = 8'h0C;
  localparam addr_t A_WIRQT  = 8'h10;
  localparam addr_t A_RIRQT  = 8'h14;
  localparam addr_t A_IRQS   = 8'h18;
  localparam addr_t A_IRQEN  = 8'h1C;
  localparam addr_t A_IRQP   = 8'h20;
  localparam addr_t A_CTRL   = 8'h24;

  logic       clk_i;
  logic       rst_i;
  logic [1:0] awvalid, awready, wvalid, wready, bvalid, bready; // index is the port
  logic [1:0] arvalid, arready, rvalid, rready, irq_o;
  addr_t      awaddr [2];
  addr_t      araddr [2];
  data_t      wdata  [2];
  data_t      rdata  [2];
  resp_e      bresp  [2];
  resp_e      rresp  [2];

  // ----------------------------------------
  // reference model with each fifo indexed by its writer port
  data_t      model_q [2][$];
  int         wirqt_m [2];
  int         rirqt_m [2];
  logic [1:0] err_m   [2];
  logic [2:0] irqs_m  [2];
  logic [2:0] irqen_m [2];

  // pending compares drained by the compare process
  string       lbl_q [$];
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];

  int seed      = 32'h98ff1a5d;
  int max_stall = 3;              // longest bready/rready low time
  int errors;
  int checks;
  int tests_run;
  int err_mark;
  int cycles;

  mbox_top dut_i (
    .clk_i, .rst_i,
    .awvalid_p0_i (awvalid[0]), .awready_p0_o (awready[0]), .awaddr_p0_i (awaddr[0]),
    .wvalid_p0_i  (wvalid[0]),  .wready_p0_o  (wready[0]),  .wdata_p0_i  (wdata[0]),
    .bvalid_p0_o  (bvalid[0]),  .bready_p0_i  (bready[0]),  .bresp_p0_o  (bresp[0]),
    .arvalid_p0_i (arvalid[0]), .arready_p0_o (arready[0]), .araddr_p0_i (araddr[0]),
    .rvalid_p0_o  (rvalid[0]),  .rready_p0_i  (rready[0]),
    .rdata_p0_o   (rdata[0]),   .rresp_p0_o   (rresp[0]),
    .awvalid_p1_i (awvalid[1]), .awready_p1_o (awready[1]), .awaddr_p1_i (awaddr[1]),
    .wvalid_p1_i  (wvalid[1]),  .wready_p1_o  (wready[1]),  .wdata_p1_i  (wdata[1]),
    .bvalid_p1_o  (bvalid[1]),  .bready_p1_i  (bready[1]),  .bresp_p1_o  (bresp[1]),
    .arvalid_p1_i (arvalid[1]), .arready_p1_o (arready[1]), .araddr_p1_i (araddr[1]),
    .rvalid_p1_o  (rvalid[1]),  .rready_p1_i  (rready[1]),
    .rdata_p1_o   (rdata[1]),   .rresp_p1_o   (rresp[1]),
    .irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // hang guard
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // checking
  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic void queue_check(string what, logic [31:0] got, logic [31:0] exp);
    lbl_q.push_back(what);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endfunction

  // compare process runs once per falling edge
  always @(negedge clk_i) begin
    while (got_q.size() != 0) begin
      check_eq(lbl_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
    end
  end

  // ----------------------------------------
  // model rules
  function automatic int limit_threshold(data_t v);
    return (v >= `MBOX_DEPTH) ? `MBOX_DEPTH - 1 : int'(v); // never reaches depth
  endfunction

  function automatic data_t status_of(int p);
    int wu;
    int ru;
    wu = model_q[p].size();
    ru = model_q[1 - p].size();
    return {28'd0, ru > rirqt_m[p], wu > wirqt_m[p], wu == `MBOX_DEPTH, ru == 0};
  endfunction

  function automatic data_t ref_read(int p, addr_t a, output resp_e resp);
    int idx;
    idx  = int'(a[7:2]);
    resp = OKAY;
    if (idx >= `MBOX_NUM_REGS) begin
      resp = SLVERR;                                // outside the map reads zero
      return '0;
    end
    case (idx)
      0: return `MBOX_MBOXW_RDVAL;
      1: begin
        if (model_q[1 - p].size() == 0) begin
          resp = SLVERR;
          return `MBOX_EMPTY_RDVAL;
        end
        return model_q[1 - p][0];                   // oldest word
      end
      2: return status_of(p);
      3: return data_t'(err_m[p]);
      4: return data_t'(wirqt_m[p]);
      5: return data_t'(rirqt_m[p]);
      6: return data_t'(irqs_m[p]);
      7: return data_t'(irqen_m[p]);
      8: return data_t'(irqs_m[p] & irqen_m[p]);
      default: return '0;                           // ctrl
    endcase
  endfunction

  function automatic resp_e ref_write_resp(int p, addr_t a);
    if (int'(a[7:2]) >= `MBOX_NUM_REGS) return SLVERR;
    if (a[7:2] == 6'd0 && model_q[p].size() == `MBOX_DEPTH) return SLVERR; // no room
    return OKAY;
  endfunction

  // level conditions set their sticky bits after every access
  function automatic void set_sticky();
    data_t st;
    for (int p = 0; p < 2; p++) begin
      st = status_of(p);
      if (st[2]) irqs_m[p][0] = 1'b1;
      if (st[3]) irqs_m[p][1] = 1'b1;
    end
  endfunction

  function automatic void apply_write(int p, addr_t a, data_t d);
    case (int'(a[7:2]))
      0: begin
        if (model_q[p].size() == `MBOX_DEPTH) begin
          err_m[p][1]  = 1'b1;
          irqs_m[p][2] = 1'b1;
        end else begin
          model_q[p].push_back(d);
        end
      end
      4: wirqt_m[p] = limit_threshold(d);
      5: rirqt_m[p] = limit_threshold(d);
      6: irqs_m[p]  = irqs_m[p] & ~d[2:0];         // write one to clear
      7: irqen_m[p] = d[2:0];
      9: begin
        if (d[0]) model_q[p].delete();              // own write fifo
        if (d[1]) model_q[1 - p].delete();          // own read fifo
      end
      default: ;
    endcase
    set_sticky();
  endfunction

  function automatic void apply_read(int p, addr_t a);
    if (a[7:2] == 6'd1) begin
      if (model_q[1 - p].size() == 0) begin
        err_m[p][0]  = 1'b1;
        irqs_m[p][2] = 1'b1;
      end else begin
        void'(model_q[1 - p].pop_front());
      end
    end else if (a[7:2] == 6'd3) begin
      err_m[p] = '0;                                // clear on read
    end
    set_sticky();
  endfunction

  // ----------------------------------------
  // bus side
  function automatic int stall_cycles();
    return {$random(seed)} % (max_stall + 1);
  endfunction

  task automatic axi_write(input int p, input addr_t a, input data_t d, output resp_e r);
    int n;
    n = stall_cycles();
    @(posedge clk_i);
    awvalid[p] <= 1'b1;
    wvalid[p]  <= 1'b1;
    awaddr[p]  <= a;
    wdata[p]   <= d;
    @(negedge clk_i);
    while (!awready[p]) @(negedge clk_i);           // b slice still busy
    queue_check($sformatf("p%0d wready with awready", p), wready[p], 1'b1);
    @(posedge clk_i);                               // aw and w taken here
    awvalid[p] <= 1'b0;
    wvalid[p]  <= 1'b0;
    @(negedge clk_i);
    queue_check($sformatf("p%0d bvalid one cycle after accept", p), bvalid[p], 1'b1);
    while (!bvalid[p]) @(negedge clk_i);
    repeat (n) @(negedge clk_i);                    // master not ready yet
    @(posedge clk_i);
    bready[p] <= 1'b1;
    @(negedge clk_i);
    queue_check($sformatf("p%0d bvalid held while stalled", p), bvalid[p], 1'b1);
    r = bresp[p];
    @(posedge clk_i);                               // response taken
    bready[p] <= 1'b0;
  endtask

  task automatic axi_read(input int p, input addr_t a, output data_t d, output resp_e r);
    int n;
    n = stall_cycles();
    @(posedge clk_i);
    arvalid[p] <= 1'b1;
    araddr[p]  <= a;
    @(negedge clk_i);
    while (!arready[p]) @(negedge clk_i);
    @(posedge clk_i);                               // ar taken and the pop happens here
    arvalid[p] <= 1'b0;
    @(negedge clk_i);
    queue_check($sformatf("p%0d rvalid one cycle after accept", p), rvalid[p], 1'b1);
    while (!rvalid[p]) @(negedge clk_i);
    repeat (n) @(negedge clk_i);
    @(posedge clk_i);
    rready[p] <= 1'b1;
    @(negedge clk_i);
    queue_check($sformatf("p%0d rvalid held while stalled", p), rvalid[p], 1'b1);
    d = rdata[p];
    r = rresp[p];
    @(posedge clk_i);
    rready[p] <= 1'b0;
  endtask

  task automatic write_reg(input int p, input addr_t a, input data_t d);
    resp_e exp_r;
    resp_e got_r;
    exp_r = ref_write_resp(p, a);
    axi_write(p, a, d, got_r);
    queue_check($sformatf("p%0d write %02h bresp", p, a), got_r, exp_r);
    apply_write(p, a, d);
  endtask

  task automatic read_reg(input int p, input addr_t a, output data_t got);
    data_t exp_d;
    resp_e exp_r;
    resp_e got_r;
    exp_d = ref_read(p, a, exp_r);
    axi_read(p, a, got, got_r);
    queue_check($sformatf("p%0d read %02h rdata", p, a), got, exp_d);
    queue_check($sformatf("p%0d read %02h rresp", p, a), got_r, exp_r);
    apply_read(p, a);
  endtask

  task automatic check_irq();
    @(negedge clk_i);
    for (int p = 0; p < 2; p++) begin
      queue_check($sformatf("p%0d irq_o", p), irq_o[p], |(irqs_m[p] & irqen_m[p]));
    end
  endtask

  task automatic finish_test(input string name);
    while (got_q.size() != 0) @(posedge clk_i);     // let the compare process catch up
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    err_mark = errors;
  endtask

  // ----------------------------------------
  // tests
  initial begin
    data_t rd;
    data_t rd_par;
    int    polls;
    int    side;
    rst_i   = 1'b1;
    awvalid = '0;
    wvalid  = '0;
    bready  = '0;
    arvalid = '0;
    rready  = '0;
    for (int p = 0; p < 2; p++) begin
      awaddr[p]  = '0;
      araddr[p]  = '0;
      wdata[p]   = '0;
      wirqt_m[p] = 0;
      rirqt_m[p] = 0;
      err_m[p]   = '0;
      irqs_m[p]  = '0;
      irqen_m[p] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    // reset values of every register but the mailbox read port
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < `MBOX_NUM_REGS; i++) begin
        if (i == 1) continue;
        read_reg(p, addr_t'(i * 4), rd);
        queue_check($sformatf("p%0d reset value of reg %0d", p, i), rd,
                    (i == 0) ? `MBOX_MBOXW_RDVAL : (i == 2) ? 32'd1 : 32'd0);
      end
    end
    check_irq();
    queue_check("irq_o after reset", irq_o, 2'b00);
    finish_test("reset values");

    // random words both ways with status on both ports every step
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < `MBOX_DEPTH; i++) begin
        write_reg(p, A_MBOXW, $random(seed));
        read_reg(0, A_STATUS, rd);
        read_reg(1, A_STATUS, rd);
      end
      for (int i = 0; i < `MBOX_DEPTH; i++) begin
        read_reg(1 - p, A_MBOXR, rd);               // order checked by the model
        read_reg(0, A_STATUS, rd);
        read_reg(1, A_STATUS, rd);
      end
    end
    finish_test("data in order both ways");

    // error cases
    read_reg(0, A_MBOXR, rd);
    queue_check("p0 empty read data", rd, `MBOX_EMPTY_RDVAL);
    read_reg(0, A_ERROR, rd);
    read_reg(0, A_ERROR, rd);
    queue_check("p0 error cleared by read", rd, 32'd0);
    read_reg(0, A_IRQS, rd);
    queue_check("p0 irqs error bit", rd[2], 1'b1);
    for (int i = 0; i < `MBOX_DEPTH; i++) write_reg(1, A_MBOXW, $random(seed));
    write_reg(1, A_MBOXW, 32'h0000_0009);            // ninth word finds no room
    read_reg(1, A_ERROR, rd);
    read_reg(1, A_ERROR, rd);
    read_reg(1, A_IRQS, rd);
    read_reg(0, 8'd40, rd);                          // first index past the map
    read_reg(1, 8'hFC, rd);
    write_reg(0, 8'd44, 32'h1);
    write_reg(0, 8'h80, 32'h5A5A_5A5A);              // low index bits alias mboxw
    read_reg(1, A_STATUS, rd);                       // alias must not have pushed
    for (int i = 0; i < `MBOX_DEPTH; i++) read_reg(0, A_MBOXR, rd);
    finish_test("error responses");

    // thresholds and the port 1 interrupt
    write_reg(0, A_WIRQT, 32'd100);
    read_reg(0, A_WIRQT, rd);
    queue_check("p0 wirqt clamped", rd, 32'd7);
    write_reg(1, A_RIRQT, 32'd2);
    write_reg(1, A_IRQS, 32'h7);                     // drop stale bits
    write_reg(1, A_IRQEN, 32'h2);
    check_irq();
    for (int i = 0; i < 3; i++) write_reg(0, A_MBOXW, $random(seed));
    polls = 0;
    rd    = '0;
    while (!rd[1] && polls < 16) begin
      read_reg(1, A_IRQP, rd);
      polls++;
    end
    if (!rd[1]) begin
      errors++;
      $display("port 1 read threshold interrupt still not pending after %0d polls", polls);
    end
    check_irq();
    queue_check("irq_o[1] raised", irq_o[1], 1'b1);
    read_reg(1, A_MBOXR, rd);
    read_reg(1, A_MBOXR, rd);
    write_reg(1, A_IRQS, 32'h2);
    check_irq();
    queue_check("irq_o[1] after clear", irq_o[1], 1'b0);
    read_reg(1, A_MBOXR, rd);
    finish_test("interrupt thresholds");

    // flush fifo a from its reader
    for (int i = 0; i < `MBOX_DEPTH; i++) write_reg(0, A_MBOXW, $random(seed));
    read_reg(0, A_STATUS, rd);
    queue_check("p0 write fifo full", rd[1], 1'b1);
    write_reg(0, A_IRQS, 32'h1);                     // still above threshold so it sets again
    write_reg(0, A_IRQEN, 32'h1);
    check_irq();
    queue_check("irq_o[0] raised by write threshold", irq_o[0], 1'b1);
    write_reg(1, A_CTRL, 32'h2);
    read_reg(1, A_STATUS, rd);
    queue_check("p1 read fifo empty after flush", rd[0], 1'b1);
    read_reg(0, A_STATUS, rd);
    queue_check("p0 write fifo not full after flush", rd[1], 1'b0);
    read_reg(1, A_CTRL, rd);
    write_reg(1, A_MBOXW, $random(seed));
    write_reg(1, A_CTRL, 32'h1);                     // writer drops its own fifo b
    read_reg(0, A_STATUS, rd);
    queue_check("p0 read fifo empty after writer flush", rd[0], 1'b1);
    finish_test("flush");

    // long stalls with a read and a write in flight together on one port
    max_stall = 7;
    for (int i = 0; i < 24; i++) begin
      side = {$random(seed)} % 2;
      fork
        write_reg(side, A_MBOXW, $random(seed));     // pushes the own fifo
        read_reg(side, A_MBOXR, rd_par);             // pops the other one
      join
    end
    read_reg(0, A_STATUS, rd);
    read_reg(1, A_STATUS, rd);
    while (model_q[0].size() != 0) read_reg(1, A_MBOXR, rd);
    while (model_q[1].size() != 0) read_reg(0, A_MBOXR, rd);
    read_reg(0, A_STATUS, rd);
    read_reg(1, A_STATUS, rd);
    check_irq();
    finish_test("back-pressure");

    while (got_q.size() != 0) @(posedge clk_i);
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
